//--- all.f
+incdir+.
rf_pkg.sv
rf_regfile.sv
rf_test_wrap.sv
rf_march_bist.sv
rf_top.sv
rf_props.sv
rf_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the register file simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module rf_tb

./obj_dir/Vrf_tb | tee sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
   echo "Simulation result: pass"
   exit 0
fi
echo "Simulation result: fail"
exit 1

//--- rf_tb.sv
// Testbench for rf_top with random traffic, reference model, BIST run and final report

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_tb;

   localparam int unsigned MAX_WAIT    = 200;
   localparam int unsigned RAND_CYCLES = 400;
   // Highest register reached by the inverted test address
   localparam int unsigned INV_MAX     = 2 ** (`RF_ADDR_W - 1) - 1;

   logic                    clk;
   logic                    rst_n;
   logic [`RF_ADDR_W-1:0]   raddr_a;
   logic [`RF_ADDR_W-1:0]   raddr_b;
   logic [`RF_ADDR_W-1:0]   raddr_c;
   logic [`RF_DATA_W-1:0]   rdata_a;
   logic [`RF_DATA_W-1:0]   rdata_b;
   logic [`RF_DATA_W-1:0]   rdata_c;
   rf_pkg::rf_wr_req_t      wr_a;
   rf_pkg::rf_wr_req_t      wr_b;
   logic                    bist_start;
   rf_pkg::rf_bist_status_t bist;

   // Reference copy of the array where x0 stays zero
   logic [`RF_DATA_W-1:0]   model [0:2**`RF_ADDR_W-1];
   logic                    in_run;
   rf_pkg::rf_bist_status_t done_seen;
   string                   test_name;
   int unsigned             data_errs;
   int unsigned             status_errs;
   int unsigned             other_errs;
   int unsigned             done_cnt;

   rf_top u_dut
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .raddr_a_i    (raddr_a),
      .raddr_b_i    (raddr_b),
      .raddr_c_i    (raddr_c),
      .rdata_a_o    (rdata_a),
      .rdata_b_o    (rdata_b),
      .rdata_c_o    (rdata_c),
      .wr_a_i       (wr_a),
      .wr_b_i       (wr_b),
      .bist_start_i (bist_start),
      .bist_o       (bist)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   function automatic rf_pkg::rf_wr_req_t rand_req();
      rf_pkg::rf_wr_req_t r;
      r.we   = 1'($urandom_range(1, 0));
      r.addr = `RF_ADDR_W'($urandom_range(2**`RF_ADDR_W-1, 0));
      r.data = $urandom();
      return r;
   endfunction

   // x0 or a register the march never touches
   function automatic logic [`RF_ADDR_W-1:0] rand_free_addr();
      int unsigned a;
      a = $urandom_range(2**`RF_ADDR_W-1, `RF_BIST_LAST + 1);
      if (a == `RF_BIST_LAST + 1)
      begin
         a = 0;
      end
      return `RF_ADDR_W'(a);
   endfunction

   task automatic check_data(input string name, input logic [`RF_DATA_W-1:0] exp,
                             input logic [`RF_DATA_W-1:0] act);
      if (act !== exp)
      begin
         data_errs++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_status(input string name, input rf_pkg::rf_bist_status_t exp,
                               input rf_pkg::rf_bist_status_t act);
      if (act !== exp)
      begin
         status_errs++;
         $write("Error %s: expected busy=%0b done=%0b fail=%0b fail_addr=%0d",
                name, exp.busy, exp.done, exp.fail, exp.fail_addr);
         $display(", actual busy=%0b done=%0b fail=%0b fail_addr=%0d",
                  act.busy, act.done, act.fail, act.fail_addr);
      end
   endtask

   // Port B goes second so it wins a clash
   // Writes to x0 are dropped
   task automatic model_write(input rf_pkg::rf_wr_req_t r);
      if (r.we && (r.addr != '0))
      begin
         model[r.addr] = r.data;
      end
   endtask

   // One clock of traffic with reads checked at the falling edge
   task automatic step(input rf_pkg::rf_wr_req_t wa, input rf_pkg::rf_wr_req_t wb,
                       input logic [`RF_ADDR_W-1:0] ra, input logic [`RF_ADDR_W-1:0] rb,
                       input logic [`RF_ADDR_W-1:0] rc, input logic start);
      @(posedge clk);
      wr_a       <= wa;
      wr_b       <= wb;
      raddr_a    <= ra;
      raddr_b    <= rb;
      raddr_c    <= rc;
      bist_start <= start;
      @(negedge clk);
      // Port A belongs to the BIST engine during a run
      if (!in_run)
      begin
         check_data({test_name, " port a"}, model[ra], rdata_a);
      end
      check_data({test_name, " port b"}, model[rb], rdata_b);
      check_data({test_name, " port c"}, model[rc], rdata_c);
      if (bist.done)
      begin
         done_cnt++;
         done_seen = bist;
         if (!in_run)
         begin
            other_errs++;
            $display("BIST done pulse appeared with no run in progress");
         end
         // Test address t lands on register INV_MAX - t and is left holding the inverse
         for (int t = 0; t <= `RF_BIST_LAST; t++)
         begin
            model[INV_MAX - t] = ~`RF_BIST_PAT;
         end
         in_run = 1'b0;
      end
      if (!in_run)
      begin
         model_write(wa);
         model_write(wb);
      end
      if (start)
      begin
         in_run = 1'b1;
      end
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin
      rf_pkg::rf_wr_req_t      wa;
      rf_pkg::rf_wr_req_t      wb;
      rf_pkg::rf_wr_req_t      prev_a;
      rf_pkg::rf_wr_req_t      prev_b;
      rf_pkg::rf_bist_status_t exp_st;
      int unsigned             waited;

      void'($urandom(60011));
      rst_n       = 1'b0;
      wr_a        = '0;
      wr_b        = '0;
      raddr_a     = '0;
      raddr_b     = '0;
      raddr_c     = '0;
      bist_start  = 1'b0;
      in_run      = 1'b0;
      data_errs   = 0;
      status_errs = 0;
      other_errs  = 0;
      done_cnt    = 0;
      prev_a      = '0;
      prev_b      = '0;
      for (int i = 0; i < 2**`RF_ADDR_W; i++)
      begin
         model[i] = '0;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      // Read back last cycle's write addresses plus one random address
      test_name = "random";
      for (int n = 0; n < RAND_CYCLES; n++)
      begin
         wa = rand_req();
         wb = rand_req();
         step(wa, wb, prev_a.addr, prev_b.addr, `RF_ADDR_W'($urandom()), 1'b0);
         prev_a = wa;
         prev_b = wb;
      end

      test_name = "zero_reg";
      repeat (8)
      begin
         wa      = rand_req();
         wb      = rand_req();
         wa.we   = 1'b1;
         wb.we   = 1'b1;
         wa.addr = '0;
         wb.addr = '0;
         step(wa, wb, '0, '0, '0, 1'b0);
      end
      step('0, '0, '0, '0, '0, 1'b0);

      test_name = "same_addr";
      repeat (16)
      begin
         wa      = rand_req();
         wa.we   = 1'b1;
         wb      = wa;
         wb.data = $urandom();
         step(wa, wb, rand_free_addr(), rand_free_addr(), rand_free_addr(), 1'b0);
         step('0, '0, wa.addr, wa.addr, wa.addr, 1'b0);
      end

      // Functional traffic keeps running while ports B and C stay off the march range
      test_name = "bist";
      done_cnt  = 0;
      step('0, '0, rand_free_addr(), rand_free_addr(), rand_free_addr(), 1'b1);
      waited = 0;
      while (in_run && (waited < MAX_WAIT))
      begin
         wa = rand_req();
         wb = rand_req();
         // A second start well inside the run must be ignored
         step(wa, wb, rand_free_addr(), rand_free_addr(), rand_free_addr(), waited == 10);
         waited++;
      end
      if (in_run)
      begin
         other_errs++;
         $display("Timeout after %0d cycles waiting for BIST done", MAX_WAIT);
      end
      else
      begin
         exp_st      = '0;
         exp_st.done = 1'b1;
         check_status("bist status", exp_st, done_seen);
      end

      // Full readback followed by enough cycles to expose a stray second run
      test_name = "after_bist";
      for (int i = 0; i < 2**`RF_ADDR_W; i++)
      begin
         step('0, '0, `RF_ADDR_W'(i), `RF_ADDR_W'(i), `RF_ADDR_W'(i), 1'b0);
      end
      repeat (40)
      begin
         step(rand_req(), rand_req(), `RF_ADDR_W'($urandom()), `RF_ADDR_W'($urandom()),
              `RF_ADDR_W'($urandom()), 1'b0);
      end
      if (done_cnt != 1)
      begin
         other_errs++;
         $display("Expected one BIST done pulse for the run but saw %0d", done_cnt);
      end

      $display("Error counts: data %0d, status %0d, other %0d",
               data_errs, status_errs, other_errs);
      if ((data_errs + status_errs + other_errs) == 0)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- rf_props.sv
// Concurrent assertions on test mode port B masking, done pulse width and BIST start

`timescale 1ns/1ps

module rf_props
(
   input logic clk,
   input logic rst_n,
   input logic test_mode_i,
   input logic wr_b_we_i,
   input logic start_i,
   input logic busy_i,
   input logic done_i
);

   // Functional port B never reaches the array during test
   a_b_masked: assert property (@(posedge clk) disable iff (!rst_n)
      test_mode_i |-> !wr_b_we_i)
      else $error("port B write enable reached the register file in test mode");

   // Done lasts exactly one clock
   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      done_i |=> !done_i)
      else $error("BIST done stayed high for more than one cycle");

   // Busy only follows a start pulse
   a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(busy_i) |-> $past(start_i))
      else $error("BIST busy rose with no start pulse");

endmodule

// Wrapper side sees test mode and the muxed port B strobe
bind rf_test_wrap rf_props u_wrap_props
(
   .clk         (clk),
   .rst_n       (rst_n),
   .test_mode_i (test_mode_i),
   .wr_b_we_i   (wr_b_mux.we),
   .start_i     (1'b0),
   .busy_i      (1'b0),
   .done_i      (1'b0)
);

// Engine side sees start, busy and done
bind rf_march_bist rf_props u_bist_props
(
   .clk         (clk),
   .rst_n       (rst_n),
   .test_mode_i (status_o.busy),
   .wr_b_we_i   (1'b0),
   .start_i     (start_i),
   .busy_i      (status_o.busy),
   .done_i      (status_o.done)
);

//--- rf_top.sv
// Top level joining the march BIST engine, the test wrapper and the register file

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_top
(
   input  logic                    clk,
   input  logic                    rst_n,

   // Functional read ports
   input  logic [`RF_ADDR_W-1:0]   raddr_a_i,
   input  logic [`RF_ADDR_W-1:0]   raddr_b_i,
   input  logic [`RF_ADDR_W-1:0]   raddr_c_i,
   output logic [`RF_DATA_W-1:0]   rdata_a_o,
   output logic [`RF_DATA_W-1:0]   rdata_b_o,
   output logic [`RF_DATA_W-1:0]   rdata_c_o,

   // Functional write ports
   input  rf_pkg::rf_wr_req_t      wr_a_i,
   input  rf_pkg::rf_wr_req_t      wr_b_i,

   // Self-test control and status
   input  logic                    bist_start_i,
   output rf_pkg::rf_bist_status_t bist_o
);

   rf_pkg::rf_test_port_t test_port;
   logic [`RF_DATA_W-1:0] test_q;

   rf_march_bist u_bist
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .start_i  (bist_start_i),
      .test_q_i (test_q),
      .test_o   (test_port),
      .status_o (bist_o)
   );

   // Busy engine owns port A
   rf_test_wrap u_wrap
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .test_mode_i (bist_o.busy),
      .raddr_a_i   (raddr_a_i),
      .raddr_b_i   (raddr_b_i),
      .raddr_c_i   (raddr_c_i),
      .rdata_a_o   (rdata_a_o),
      .rdata_b_o   (rdata_b_o),
      .rdata_c_o   (rdata_c_o),
      .wr_a_i      (wr_a_i),
      .wr_b_i      (wr_b_i),
      .test_i      (test_port),
      .test_q_o    (test_q)
   );

endmodule

//--- rf_march_bist.sv
// March BIST engine driving the test port, comparing read data, flagging failures

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_march_bist
(
   input  logic                    clk,
   input  logic                    rst_n,

   // One-cycle start pulse, ignored while busy
   input  logic                    start_i,

   // Read data returned by the wrapper
   input  logic [`RF_DATA_W-1:0]   test_q_i,

   output rf_pkg::rf_test_port_t   test_o,
   output rf_pkg::rf_bist_status_t status_o
);

   localparam int unsigned CNT_W = `RF_ADDR_W - 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RF_BIST_LAST);
   localparam logic [`RF_DATA_W-1:0] PAT = `RF_BIST_PAT;

   // Write up, read-and-invert up, read down, drain
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WR,
      ST_RDW,
      ST_RD,
      ST_END
   } state_t;

   state_t                state_q;
   logic [CNT_W-1:0]      addr_q;
   logic                  wr_step_q;
   logic                  issue_rd;
   logic [`RF_DATA_W-1:0] exp_d;

   // Compare slot for the read issued last cycle
   logic                  cmp_valid_q;
   logic [`RF_DATA_W-1:0] cmp_exp_q;
   logic [`RF_ADDR_W-1:0] cmp_addr_q;

   logic                  done_q;
   logic                  fail_q;
   logic [`RF_ADDR_W-1:0] fail_addr_q;

   //////////////////////////////
   // Test port drive
   //////////////////////////////

   always_comb
   begin
      test_o.csn  = 1'b1;
      test_o.wen  = 1'b1;
      test_o.addr = {1'b0, addr_q};
      test_o.data = PAT;
      exp_d       = PAT;
      case (state_q)
         ST_WR:
         begin
            test_o.csn = 1'b0;
            test_o.wen = 1'b0;
         end
         ST_RDW:
         begin
            // Read the pattern, then overwrite with its inverse
            test_o.csn  = 1'b0;
            test_o.wen  = !wr_step_q;
            test_o.data = ~PAT;
         end
         ST_RD:
         begin
            test_o.csn = 1'b0;
            exp_d      = ~PAT;
         end
         default:
         begin
         end
      endcase
   end

   assign issue_rd = !test_o.csn && test_o.wen;

   //////////////////////////////
   // Sequencer and checker
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= ST_IDLE;
         addr_q      <= '0;
         wr_step_q   <= 1'b0;
         cmp_valid_q <= 1'b0;
         done_q      <= 1'b0;
         fail_q      <= 1'b0;
         fail_addr_q <= '0;
      end
      else
      begin
         done_q      <= 1'b0;
         cmp_valid_q <= issue_rd;

         // Only the first mismatch is kept
         if (cmp_valid_q && (test_q_i != cmp_exp_q) && !fail_q)
         begin
            fail_q      <= 1'b1;
            fail_addr_q <= cmp_addr_q;
         end

         case (state_q)
            ST_IDLE:
            begin
               if (start_i)
               begin
                  state_q     <= ST_WR;
                  addr_q      <= '0;
                  wr_step_q   <= 1'b0;
                  fail_q      <= 1'b0;
                  fail_addr_q <= '0;
               end
            end
            ST_WR:
            begin
               if (addr_q == CNT_LAST)
               begin
                  state_q <= ST_RDW;
                  addr_q  <= '0;
               end
               else
               begin
                  addr_q <= addr_q + 1'b1;
               end
            end
            ST_RDW:
            begin
               wr_step_q <= !wr_step_q;
               if (wr_step_q)
               begin
                  // Descending element starts from the last address
                  if (addr_q == CNT_LAST)
                  begin
                     state_q <= ST_RD;
                  end
                  else
                  begin
                     addr_q <= addr_q + 1'b1;
                  end
               end
            end
            ST_RD:
            begin
               if (addr_q == '0)
               begin
                  state_q <= ST_END;
               end
               else
               begin
                  addr_q <= addr_q - 1'b1;
               end
            end
            default:
            begin
               // Last compare lands here, then report
               state_q <= ST_IDLE;
               done_q  <= 1'b1;
            end
         endcase
      end
   end

   // Expected value and address ride along with the read
   always_ff @(posedge clk)
   begin
      cmp_exp_q  <= exp_d;
      cmp_addr_q <= test_o.addr;
   end

   assign status_o.busy      = (state_q != ST_IDLE);
   assign status_o.done      = done_q;
   assign status_o.fail      = fail_q;
   assign status_o.fail_addr = fail_addr_q;

endmodule

//--- rf_test_wrap.sv
// Test wrapper giving the register file one BIST port on write A and read A

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_test_wrap
(
   input  logic                  clk,
   input  logic                  rst_n,

   // High while the BIST engine owns port A
   input  logic                  test_mode_i,

   // Functional read ports
   input  logic [`RF_ADDR_W-1:0] raddr_a_i,
   input  logic [`RF_ADDR_W-1:0] raddr_b_i,
   input  logic [`RF_ADDR_W-1:0] raddr_c_i,
   output logic [`RF_DATA_W-1:0] rdata_a_o,
   output logic [`RF_DATA_W-1:0] rdata_b_o,
   output logic [`RF_DATA_W-1:0] rdata_c_o,

   // Functional write ports
   input  rf_pkg::rf_wr_req_t    wr_a_i,
   input  rf_pkg::rf_wr_req_t    wr_b_i,

   // BIST collar side
   input  rf_pkg::rf_test_port_t test_i,
   output logic [`RF_DATA_W-1:0] test_q_o
);

   rf_pkg::rf_wr_req_t    wr_a_mux;
   rf_pkg::rf_wr_req_t    wr_b_mux;
   logic [`RF_ADDR_W-1:0] raddr_a_mux;
   logic [`RF_ADDR_W-1:0] test_addr_map;
   logic [`RF_ADDR_W-1:0] test_raddr_q;
   logic                  test_rd;
   logic                  test_wr;

   // Decode of the active-low strobes
   assign test_rd = !test_i.csn && test_i.wen;
   assign test_wr = !test_i.csn && !test_i.wen;

   // MSB dropped and low bits inverted, test address 0 lands on x15
   assign test_addr_map = {1'b0, ~test_i.addr[`RF_ADDR_W-2:0]};

   //////////////////////////////
   // Port muxing
   //////////////////////////////

   always_comb
   begin
      wr_a_mux = wr_a_i;
      wr_b_mux = wr_b_i;
      if (test_mode_i)
      begin
         wr_a_mux.we   = test_wr;
         wr_a_mux.addr = test_addr_map;
         wr_a_mux.data = test_i.data;
         // Functional port B writes are dropped during test
         wr_b_mux      = '0;
      end
   end

   assign raddr_a_mux = test_mode_i ? test_raddr_q : raddr_a_i;

   // Test read address, data shows on port A the cycle after issue
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         test_raddr_q <= '0;
      end
      else if (test_mode_i && test_rd)
      begin
         test_raddr_q <= test_addr_map;
      end
   end

   assign test_q_o = rdata_a_o;

   rf_regfile u_regfile
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .raddr_a_i (raddr_a_mux),
      .raddr_b_i (raddr_b_i),
      .raddr_c_i (raddr_c_i),
      .rdata_a_o (rdata_a_o),
      .rdata_b_o (rdata_b_o),
      .rdata_c_o (rdata_c_o),
      .wr_a_i    (wr_a_mux),
      .wr_b_i    (wr_b_mux)
   );

endmodule

//--- rf_regfile.sv
// Integer register file, 32 words, three combinational reads and two writes

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_regfile
(
   input  logic                  clk,
   input  logic                  rst_n,

   // Read ports, answered in the same cycle
   input  logic [`RF_ADDR_W-1:0] raddr_a_i,
   input  logic [`RF_ADDR_W-1:0] raddr_b_i,
   input  logic [`RF_ADDR_W-1:0] raddr_c_i,
   output logic [`RF_DATA_W-1:0] rdata_a_o,
   output logic [`RF_DATA_W-1:0] rdata_b_o,
   output logic [`RF_DATA_W-1:0] rdata_c_o,

   // Write ports, B has priority on a clash
   input  rf_pkg::rf_wr_req_t    wr_a_i,
   input  rf_pkg::rf_wr_req_t    wr_b_i
);

   localparam int unsigned RF_WORDS = 2 ** `RF_ADDR_W;

   // Storage for x1..x31, x0 has no flops
   logic [`RF_DATA_W-1:0] mem_q [1:RF_WORDS-1];

   //////////////////////////////
   // Write decode
   //////////////////////////////

   for (genvar i = 1; i < RF_WORDS; i++)
   begin : g_word
      localparam logic [`RF_ADDR_W-1:0] WORD_ADDR = `RF_ADDR_W'(i);

      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
         begin
            mem_q[i] <= '0;
         end
         // Port B checked first so it wins a same-address write
         else if (wr_b_i.we && (wr_b_i.addr == WORD_ADDR))
         begin
            mem_q[i] <= wr_b_i.data;
         end
         else if (wr_a_i.we && (wr_a_i.addr == WORD_ADDR))
         begin
            mem_q[i] <= wr_a_i.data;
         end
      end
   end

   //////////////////////////////
   // Read muxes
   //////////////////////////////

   // x0 always reads zero
   function automatic logic [`RF_DATA_W-1:0] read_word(input logic [`RF_ADDR_W-1:0] addr);
      if (addr == '0)
      begin
         return '0;
      end
      return mem_q[addr];
   endfunction

   assign rdata_a_o = read_word(raddr_a_i);
   assign rdata_b_o = read_word(raddr_b_i);
   assign rdata_c_o = read_word(raddr_c_i);

endmodule

//--- rf_pkg.sv
// Package with the write request, BIST test port and BIST status structs

`include "rf_params.svh"

package rf_pkg;

   //////////////////////////////
   // Functional write port
   //////////////////////////////

   // One write strobe per cycle, no handshake
   typedef struct packed {
      logic                  we;
      logic [`RF_ADDR_W-1:0] addr;
      logic [`RF_DATA_W-1:0] data;
   } rf_wr_req_t;

   //////////////////////////////
   // BIST collar interface
   //////////////////////////////

   // One-port test access, strobes active low
   // Read is csn low with wen high, write is csn low with wen low
   typedef struct packed {
      logic                  csn;
      logic                  wen;
      logic [`RF_ADDR_W-1:0] addr;
      logic [`RF_DATA_W-1:0] data;
   } rf_test_port_t;

   // Engine status, fail and fail_addr hold until the next start
   typedef struct packed {
      logic                  busy;
      logic                  done;
      logic                  fail;
      logic [`RF_ADDR_W-1:0] fail_addr;
   } rf_bist_status_t;

endpackage

//--- rf_params.svh
// Register file geometry, BIST background pattern and BIST test address range

`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

//////////////////////////////
// Register file geometry
//////////////////////////////

// Bits per register address, 32 entries
`define RF_ADDR_W 5

// Bits per register word
`define RF_DATA_W 32

//////////////////////////////
// March BIST settings
//////////////////////////////

// Background written in the first march element, inverted in the second
`define RF_BIST_PAT 32'hA5C3_3C5A

// Last test address, 0..14 map to x15..x1 (x0 cannot be written)
`define RF_BIST_LAST 14

`endif
